/* verilog/trdb_pkg.sv */
package trdb_pkg;

    // datapath and bus sizes
    localparam int unsigned XLEN           = 32;
    localparam int unsigned REG_ADDR_WIDTH = 5;

    // software FIFO geometry
    localparam int unsigned SW_FIFO_DEPTH = 4;
    localparam int unsigned SW_PTR_WIDTH  = $clog2(SW_FIFO_DEPTH);
    localparam int unsigned SW_CNT_WIDTH  = $clog2(SW_FIFO_DEPTH + 1);

    // register map, byte offsets on the peripheral port
    localparam logic [REG_ADDR_WIDTH-1:0] REG_TRDB_CFG            = 5'h00;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_TRDB_CTRL           = 5'h04;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_TRDB_STATUS         = 5'h08;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_TRDB_DUMP           = 5'h0C;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_TRDB_DUMP_WITH_TIME = 5'h10;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_TRDB_LOWER_ADDR     = 5'h14;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_TRDB_HIGHER_ADDR    = 5'h18;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_TRDB_TIME           = 5'h1C;

    // CFG register layout
    localparam int unsigned TRDB_CFG_SIZE             = 7;
    localparam int unsigned TRDB_ENABLE               = 0;
    localparam int unsigned TRDB_TRACE_ACTIVATED      = 1;
    localparam int unsigned TRDB_APPLY_FILTERS        = 2;
    localparam int unsigned TRDB_TRACE_SELECTED_PRIV  = 3;
    localparam int unsigned TRDB_TRACE_RANGE          = 4;
    localparam int unsigned TRDB_WHICH_PRIV_LSB       = 5;
    localparam int unsigned TRDB_WHICH_PRIV_MSB       = 6;

    // CTRL register layout
    localparam int unsigned TRDB_FLUSH_STREAM = 0;

    // STATUS register layout
    // overflow is sticky, empty follows the FIFO
    localparam int unsigned TRDB_OVERFLOW = 0;
    localparam int unsigned TRDB_SW_EMPTY = 1;

    // kind of word on the output stream
    typedef enum logic [1:0] {
        KIND_ADDR = 2'd0,
        KIND_SW   = 2'd1,
        KIND_TIME = 2'd2
    } trdb_kind_e;

    // one software dump as queued in the FIFO
    typedef struct packed {
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] timestamp;
        logic            timed;
    } trdb_sw_entry_t;

endpackage

/* verilog/trdb_cfg_if.sv */
`timescale 1ns/10ps

interface trdb_cfg_if;
    import trdb_pkg::*;

    // global trace switches
    logic            enable;
    logic            activated;
    logic            apply_filters;

    // privilege filter
    logic            selected_priv;
    logic [1:0]      which_priv;

    // address range filter, bounds inclusive
    logic            range;
    logic [XLEN-1:0] lower_addr;
    logic [XLEN-1:0] higher_addr;

    // register block owns every field
    modport reg_mp (
        output enable, activated, apply_filters, selected_priv, which_priv,
        output range, lower_addr, higher_addr
    );

    // filter only looks at the settings
    modport filter_mp (
        input enable, activated, apply_filters, selected_priv, which_priv,
        input range, lower_addr, higher_addr
    );

endinterface

/* verilog/trdb_reg.sv */
`timescale 1ns/10ps

module trdb_reg (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                per_valid_i,
    input  logic                                per_we_i,
    input  logic [trdb_pkg::REG_ADDR_WIDTH-1:0] per_addr_i,
    input  logic [trdb_pkg::XLEN-1:0]           per_wdata_i,
    output logic [trdb_pkg::XLEN-1:0]           per_rdata_o,
    output logic                                per_ready_o,
    trdb_cfg_if.reg_mp                          cfg,
    output logic                                sw_push_o,
    output trdb_pkg::trdb_sw_entry_t            sw_entry_o,
    input  logic                                sw_full_i,
    input  logic                                sw_empty_i,
    output logic                                flush_req_o,
    input  logic                                flush_confirm_i
);
    import trdb_pkg::*;

    // configuration and control state
    logic [TRDB_CFG_SIZE-1:0] cfg_q, cfg_d;
    logic                     ctrl_q, ctrl_d;
    logic                     ctrl_wr;
    logic [XLEN-1:0]          lower_addr_q, lower_addr_d;
    logic [XLEN-1:0]          higher_addr_q, higher_addr_d;
    logic                     overflow_q, overflow_d;

    // free running timestamp
    logic [XLEN-1:0]          time_q;

    // dump staging, entry goes into the FIFO one cycle after the write
    trdb_sw_entry_t           entry_q, entry_d;
    logic                     push_q, push_d;

    // peripheral port answers every access at once
    assign per_ready_o = 1'b1;

    // trace settings straight out of the registers
    assign cfg.enable        = cfg_q[TRDB_ENABLE];
    assign cfg.activated     = cfg_q[TRDB_TRACE_ACTIVATED];
    assign cfg.apply_filters = cfg_q[TRDB_APPLY_FILTERS];
    assign cfg.selected_priv = cfg_q[TRDB_TRACE_SELECTED_PRIV];
    assign cfg.which_priv    = cfg_q[TRDB_WHICH_PRIV_MSB:TRDB_WHICH_PRIV_LSB];
    assign cfg.range         = cfg_q[TRDB_TRACE_RANGE];
    assign cfg.lower_addr    = lower_addr_q;
    assign cfg.higher_addr   = higher_addr_q;

    assign flush_req_o = ctrl_q;
    assign sw_push_o   = push_q;
    assign sw_entry_o  = entry_q;

    // reads are combinational, dump registers and holes read as zero
    always_comb begin : read_reg
        per_rdata_o = '0;
        if (per_valid_i && !per_we_i) begin
            case (per_addr_i)
                REG_TRDB_CFG:         per_rdata_o[TRDB_CFG_SIZE-1:0] = cfg_q;
                REG_TRDB_CTRL:        per_rdata_o[TRDB_FLUSH_STREAM] = ctrl_q;
                REG_TRDB_STATUS: begin
                    per_rdata_o[TRDB_OVERFLOW] = overflow_q;
                    per_rdata_o[TRDB_SW_EMPTY] = sw_empty_i;
                end
                REG_TRDB_LOWER_ADDR:  per_rdata_o = lower_addr_q;
                REG_TRDB_HIGHER_ADDR: per_rdata_o = higher_addr_q;
                REG_TRDB_TIME:        per_rdata_o = time_q;
                default:              per_rdata_o = '0;
            endcase
        end
    end

    always_comb begin : write_reg
        cfg_d         = cfg_q;
        ctrl_d        = ctrl_q;
        ctrl_wr       = 1'b0;
        lower_addr_d  = lower_addr_q;
        higher_addr_d = higher_addr_q;
        overflow_d    = overflow_q;
        entry_d       = entry_q;
        push_d        = 1'b0;

        if (per_valid_i && per_we_i) begin
            case (per_addr_i)
                REG_TRDB_CFG: cfg_d = per_wdata_i[TRDB_CFG_SIZE-1:0];
                REG_TRDB_CTRL: begin
                    ctrl_d  = per_wdata_i[TRDB_FLUSH_STREAM];
                    ctrl_wr = 1'b1;
                end
                REG_TRDB_STATUS: begin
                    // write one to clear
                    if (per_wdata_i[TRDB_OVERFLOW]) begin
                        overflow_d = 1'b0;
                    end
                end
                REG_TRDB_DUMP: begin
                    entry_d = '{data: per_wdata_i, timestamp: time_q, timed: 1'b0};
                    push_d  = 1'b1;
                end
                REG_TRDB_DUMP_WITH_TIME: begin
                    // stamp with the counter value at the accepting edge
                    entry_d = '{data: per_wdata_i, timestamp: time_q, timed: 1'b1};
                    push_d  = 1'b1;
                end
                REG_TRDB_LOWER_ADDR:  lower_addr_d  = per_wdata_i;
                REG_TRDB_HIGHER_ADDR: higher_addr_d = per_wdata_i;
                default: ;
            endcase
        end

        // confirmed flush drops the request, a CTRL write in the same cycle wins
        if (flush_confirm_i && !ctrl_wr) begin
            ctrl_d = 1'b0;
        end

        // entry pushed into a full FIFO is lost, remember it
        if (push_q && sw_full_i) begin
            overflow_d = 1'b1;
        end
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            cfg_q         <= '0;
            ctrl_q        <= 1'b0;
            lower_addr_q  <= '0;
            higher_addr_q <= '0;
            overflow_q    <= 1'b0;
            push_q        <= 1'b0;
            time_q        <= '0;
        end else begin
            cfg_q         <= cfg_d;
            ctrl_q        <= ctrl_d;
            lower_addr_q  <= lower_addr_d;
            higher_addr_q <= higher_addr_d;
            overflow_q    <= overflow_d;
            push_q        <= push_d;
            time_q        <= time_q + 1'b1;
        end
    end

    // payload only, qualified by push_q
    always_ff @(posedge clk_i) begin
        entry_q <= entry_d;
    end

endmodule

/* verilog/trdb_filter.sv */
`timescale 1ns/10ps

module trdb_filter (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    trdb_cfg_if.filter_mp             cfg,
    input  logic                      retire_valid_i,
    input  logic [trdb_pkg::XLEN-1:0] retire_addr_i,
    input  logic [1:0]                retire_priv_i,
    output logic                      pkt_valid_o,
    output logic [trdb_pkg::XLEN-1:0] pkt_addr_o
);
    import trdb_pkg::*;

    logic            trace_on;
    logic            priv_ok;
    logic            range_ok;
    logic            qualify;
    logic            pkt_valid_q;
    logic [XLEN-1:0] pkt_addr_q;

    // both switches must be set before anything is traced
    assign trace_on = cfg.enable & cfg.activated;

    // each filter passes everything unless it is selected
    always_comb begin
        priv_ok  = 1'b1;
        range_ok = 1'b1;
        if (cfg.apply_filters) begin
            if (cfg.selected_priv) begin
                priv_ok = (retire_priv_i == cfg.which_priv);
            end
            // inclusive on both ends
            if (cfg.range) begin
                range_ok = (retire_addr_i >= cfg.lower_addr) &&
                           (retire_addr_i <= cfg.higher_addr);
            end
        end
    end

    assign qualify = retire_valid_i & trace_on & priv_ok & range_ok;

    // one cycle packet strobe
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            pkt_valid_q <= 1'b0;
        end else begin
            pkt_valid_q <= qualify;
        end
    end

    // address only matters while the strobe is up
    always_ff @(posedge clk_i) begin
        if (qualify) begin
            pkt_addr_q <= retire_addr_i;
        end
    end

    assign pkt_valid_o = pkt_valid_q;
    assign pkt_addr_o  = pkt_addr_q;

endmodule

/* verilog/trdb_sw_fifo.sv */
`timescale 1ns/10ps

module trdb_sw_fifo (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     push_i,
    input  trdb_pkg::trdb_sw_entry_t entry_i,
    input  logic                     pop_i,
    output trdb_pkg::trdb_sw_entry_t head_o,
    output logic                     full_o,
    output logic                     empty_o
);
    import trdb_pkg::*;

    trdb_sw_entry_t          mem_q [SW_FIFO_DEPTH];
    logic [SW_PTR_WIDTH-1:0] wr_ptr_q;
    logic [SW_PTR_WIDTH-1:0] rd_ptr_q;
    logic [SW_CNT_WIDTH-1:0] count_q;
    logic                    do_push;
    logic                    do_pop;

    assign full_o  = (count_q == SW_CNT_WIDTH'(SW_FIFO_DEPTH));
    assign empty_o = (count_q == '0);

    // push into a full buffer and pop from an empty one do nothing
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    assign head_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // depth is a power of two so pointers wrap on their own
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

endmodule

/* verilog/trdb_stream_arbiter.sv */
`timescale 1ns/10ps

module trdb_stream_arbiter (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      pkt_valid_i,
    input  logic [trdb_pkg::XLEN-1:0] pkt_addr_i,
    input  trdb_pkg::trdb_sw_entry_t  sw_head_i,
    input  logic                      sw_empty_i,
    output logic                      sw_pop_o,
    input  logic                      flush_req_i,
    output logic                      flush_confirm_o,
    output logic                      stream_valid_o,
    output logic [trdb_pkg::XLEN-1:0] stream_data_o,
    output trdb_pkg::trdb_kind_e      stream_kind_o
);
    import trdb_pkg::*;

    // set while the head entry has its time word out but not its data
    logic            time_sent_q, time_sent_d;
    logic            confirm_q;

    logic            out_valid_d;
    logic [XLEN-1:0] out_data_d;
    trdb_kind_e      out_kind_d;

    logic            out_valid_q;
    logic [XLEN-1:0] out_data_q;
    trdb_kind_e      out_kind_q;

    always_comb begin
        out_valid_d = 1'b0;
        out_data_d  = pkt_addr_i;
        out_kind_d  = KIND_ADDR;
        sw_pop_o    = 1'b0;
        time_sent_d = time_sent_q;

        if (pkt_valid_i) begin
            // packets always take the slot
            out_valid_d = 1'b1;
        end else if (!sw_empty_i) begin
            out_valid_d = 1'b1;
            if (sw_head_i.timed && !time_sent_q) begin
                // timestamp first, entry stays at the head
                out_data_d  = sw_head_i.timestamp;
                out_kind_d  = KIND_TIME;
                time_sent_d = 1'b1;
            end else begin
                out_data_d  = sw_head_i.data;
                out_kind_d  = KIND_SW;
                sw_pop_o    = 1'b1;
                time_sent_d = 1'b0;
            end
        end
    end

    // flush is done once nothing is buffered and no entry is split
    // only the first such cycle confirms
    assign flush_confirm_o = flush_req_i & sw_empty_i & ~time_sent_q & ~confirm_q;

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            time_sent_q <= 1'b0;
            confirm_q   <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            time_sent_q <= time_sent_d;
            confirm_q   <= flush_confirm_o;
            out_valid_q <= out_valid_d;
        end
    end

    // word and kind are only looked at with the strobe
    always_ff @(posedge clk_i) begin
        out_data_q <= out_data_d;
        out_kind_q <= out_kind_d;
    end

    assign stream_valid_o = out_valid_q;
    assign stream_data_o  = out_data_q;
    assign stream_kind_o  = out_kind_q;

endmodule

/* verilog/trace_debugger.sv */
`timescale 1ns/10ps

module trace_debugger (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                per_valid_i,
    input  logic                                per_we_i,
    input  logic [trdb_pkg::REG_ADDR_WIDTH-1:0] per_addr_i,
    input  logic [trdb_pkg::XLEN-1:0]           per_wdata_i,
    output logic [trdb_pkg::XLEN-1:0]           per_rdata_o,
    output logic                                per_ready_o,
    input  logic                                retire_valid_i,
    input  logic [trdb_pkg::XLEN-1:0]           retire_addr_i,
    input  logic [1:0]                          retire_priv_i,
    output logic                                stream_valid_o,
    output logic [trdb_pkg::XLEN-1:0]           stream_data_o,
    output trdb_pkg::trdb_kind_e                stream_kind_o
);
    import trdb_pkg::*;

    // filter to arbiter
    logic            pkt_valid;
    logic [XLEN-1:0] pkt_addr;

    // software path
    logic            sw_push;
    trdb_sw_entry_t  sw_entry;
    trdb_sw_entry_t  sw_head;
    logic            sw_full;
    logic            sw_empty;
    logic            sw_pop;

    // flush handshake
    logic            flush_req;
    logic            flush_confirm;

    trdb_cfg_if cfg_if ();

    trdb_reg trdb_reg_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .per_valid_i     (per_valid_i),
        .per_we_i        (per_we_i),
        .per_addr_i      (per_addr_i),
        .per_wdata_i     (per_wdata_i),
        .per_rdata_o     (per_rdata_o),
        .per_ready_o     (per_ready_o),
        .cfg             (cfg_if.reg_mp),
        .sw_push_o       (sw_push),
        .sw_entry_o      (sw_entry),
        .sw_full_i       (sw_full),
        .sw_empty_i      (sw_empty),
        .flush_req_o     (flush_req),
        .flush_confirm_i (flush_confirm)
    );

    trdb_filter trdb_filter_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .cfg            (cfg_if.filter_mp),
        .retire_valid_i (retire_valid_i),
        .retire_addr_i  (retire_addr_i),
        .retire_priv_i  (retire_priv_i),
        .pkt_valid_o    (pkt_valid),
        .pkt_addr_o     (pkt_addr)
    );

    trdb_sw_fifo trdb_sw_fifo_inst (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (sw_push),
        .entry_i (sw_entry),
        .pop_i   (sw_pop),
        .head_o  (sw_head),
        .full_o  (sw_full),
        .empty_o (sw_empty)
    );

    trdb_stream_arbiter trdb_stream_arbiter_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .pkt_valid_i     (pkt_valid),
        .pkt_addr_i      (pkt_addr),
        .sw_head_i       (sw_head),
        .sw_empty_i      (sw_empty),
        .sw_pop_o        (sw_pop),
        .flush_req_i     (flush_req),
        .flush_confirm_o (flush_confirm),
        .stream_valid_o  (stream_valid_o),
        .stream_data_o   (stream_data_o),
        .stream_kind_o   (stream_kind_o)
    );

endmodule

/* dv/trace_debugger_asserts.sv */
`timescale 1ns/10ps

module trace_debugger_asserts (
    input logic                 clk_i,
    input logic                 rst_ni,
    input logic                 sw_empty_i,
    input logic                 sw_pop_i,
    input logic                 flush_req_i,
    input logic                 flush_confirm_i,
    input logic                 stream_valid_i,
    input trdb_pkg::trdb_kind_e stream_kind_i
);
    import trdb_pkg::*;

    // number of failed assertions, watched by the testbench
    int unsigned fail_count = 0;

    // a timestamp word is always followed by something else
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (stream_valid_i && stream_kind_i == KIND_TIME) |=>
            !(stream_valid_i && stream_kind_i == KIND_TIME))
    else begin
        fail_count++;
        $error("two timestamp words in a row on the stream");
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni) sw_pop_i |-> !sw_empty_i)
    else begin
        fail_count++;
        $error("software FIFO popped while empty");
    end

    // confirmation only answers a pending request
    assert property (@(posedge clk_i) disable iff (!rst_ni) flush_confirm_i |-> flush_req_i)
    else begin
        fail_count++;
        $error("flush confirmed without a request");
    end

endmodule

/* dv/trace_debugger_tb.sv */
`timescale 1ns/10ps

module trace_debugger_tb;
    import trdb_pkg::*;

    logic                      clk_i;
    logic                      rst_ni;
    logic                      per_valid_i;
    logic                      per_we_i;
    logic [REG_ADDR_WIDTH-1:0] per_addr_i;
    logic [XLEN-1:0]           per_wdata_i;
    logic [XLEN-1:0]           per_rdata_o;
    logic                      per_ready_o;
    logic                      retire_valid_i;
    logic [XLEN-1:0]           retire_addr_i;
    logic [1:0]                retire_priv_i;
    logic                      stream_valid_o;
    logic [XLEN-1:0]           stream_data_o;
    trdb_kind_e                stream_kind_o;

    // expected output, packets carry the cycle they must show up in
    logic [XLEN-1:0] exp_pkt_addr[$];
    int unsigned     exp_pkt_cycle[$];
    logic [1:0]      exp_sw_kind[$];
    logic [XLEN-1:0] exp_sw_data[$];

    // cycles since reset release, equal to the DUT timestamp in the same cycle
    int unsigned cycle_cnt = 0;
    int unsigned total_cycles = 0;
    int unsigned cycle_limit = 0;

    trace_debugger trace_debugger_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .per_valid_i    (per_valid_i),
        .per_we_i       (per_we_i),
        .per_addr_i     (per_addr_i),
        .per_wdata_i    (per_wdata_i),
        .per_rdata_o    (per_rdata_o),
        .per_ready_o    (per_ready_o),
        .retire_valid_i (retire_valid_i),
        .retire_addr_i  (retire_addr_i),
        .retire_priv_i  (retire_priv_i),
        .stream_valid_o (stream_valid_o),
        .stream_data_o  (stream_data_o),
        .stream_kind_o  (stream_kind_o)
    );

    bind trdb_stream_arbiter trace_debugger_asserts trace_debugger_asserts_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .sw_empty_i      (sw_empty_i),
        .sw_pop_i        (sw_pop_o),
        .flush_req_i     (flush_req_i),
        .flush_confirm_i (flush_confirm_o),
        .stream_valid_i  (stream_valid_o),
        .stream_kind_i   (stream_kind_o)
    );

    // 4 ns clock
    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #2 clk_i = ~clk_i;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                               input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s, got %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic drive_idle();
        per_valid_i    = 1'b0;
        per_we_i       = 1'b0;
        per_addr_i     = '0;
        per_wdata_i    = '0;
        retire_valid_i = 1'b0;
        retire_addr_i  = '0;
        retire_priv_i  = 2'd0;
    endtask

    // move to 1 ns after the next rising edge
    task automatic step();
        @(posedge clk_i);
        #1;
        drive_idle();
    endtask

    task automatic start_write(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
                               input logic [XLEN-1:0] keep);
        per_valid_i = 1'b1;
        per_we_i    = 1'b1;
        per_addr_i  = addr[REG_ADDR_WIDTH-1:0];
        per_wdata_i = data;
        // timed dump is stamped with the count of the cycle it is accepted in
        if (keep[0] && per_addr_i == REG_TRDB_DUMP_WITH_TIME) begin
            exp_sw_kind.push_back(KIND_TIME);
            exp_sw_data.push_back(cycle_cnt);
        end
        if (keep[0] &&
            (per_addr_i == REG_TRDB_DUMP || per_addr_i == REG_TRDB_DUMP_WITH_TIME)) begin
            exp_sw_kind.push_back(KIND_SW);
            exp_sw_data.push_back(data);
        end
    endtask

    task automatic start_retire(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] priv,
                                input logic [XLEN-1:0] pass);
        retire_valid_i = 1'b1;
        retire_addr_i  = addr;
        retire_priv_i  = priv[1:0];
        // filter edge plus output edge
        if (pass[0]) begin
            exp_pkt_addr.push_back(addr);
            exp_pkt_cycle.push_back(cycle_cnt + 2);
        end
    endtask

    // read data is combinational, sample late in the cycle
    task automatic bus_read(input logic [XLEN-1:0] addr, output logic [XLEN-1:0] data);
        per_valid_i = 1'b1;
        per_we_i    = 1'b0;
        per_addr_i  = addr[REG_ADDR_WIDTH-1:0];
        #2;
        data = per_rdata_o;
        // the port never stalls
        check_value(per_ready_o, 1, "peripheral ready");
        step();
    endtask

    always @(posedge clk_i) begin : watchdog
        if (rst_ni) begin
            cycle_cnt++;
        end
        total_cycles++;
        if (cycle_limit != 0 && total_cycles > cycle_limit) begin
            abort_run($sformatf("timeout: run still busy after %0d cycles", total_cycles));
        end
    end

    // stream outputs change on the rising edge, look at them on the falling one
    always @(negedge clk_i) begin : stream_monitor
        if (trace_debugger_inst.trdb_stream_arbiter_inst.trace_debugger_asserts_inst.fail_count
            != 0) begin
            abort_run("an assertion on the stream arbiter failed");
        end
        if (rst_ni && stream_valid_o) begin
            if (stream_kind_o == KIND_ADDR) begin
                if (exp_pkt_addr.size() == 0) begin
                    abort_run("address packet on the stream while none was expected");
                end
                check_value(stream_data_o, exp_pkt_addr.pop_front(), "packet address");
                check_value(cycle_cnt, exp_pkt_cycle.pop_front(), "packet output cycle");
            end else begin
                if (exp_sw_data.size() == 0) begin
                    abort_run("software word on the stream while none was expected");
                end
                check_value(stream_kind_o, exp_sw_kind.pop_front(), "software word kind");
                check_value(stream_data_o, exp_sw_data.pop_front(), "software word data");
            end
        end
    end

    initial begin : main_seq
        int              fd;
        string           line;
        string           cmds[$];
        byte             op;
        logic [XLEN-1:0] arg0, arg1, arg2, arg3, arg4, arg5;
        logic [XLEN-1:0] rd;
        logic [XLEN-1:0] exp_time;
        int              drain_cycles;

        rst_ni = 1'b0;
        drive_idle();

        fd = $fopen("dv/trace_debugger_stim.txt", "r");
        if (fd == 0) begin
            abort_run("could not open dv/trace_debugger_stim.txt");
        end
        // keep command lines, drop comments and blank lines
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                cmds.push_back(line);
            end
        end
        $fclose(fd);
        cycle_limit = 20 * cmds.size() + 16;

        repeat (16) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        foreach (cmds[i]) begin
            op = 0;
            void'($sscanf(cmds[i], "%c %h %h %h %h %h %h", op, arg0, arg1, arg2, arg3, arg4,
                          arg5));
            case (op)
                "W": begin
                    start_write(arg0, arg1, arg2);
                    step();
                end
                "M": begin
                    start_write(arg0, arg1, arg2);
                    start_retire(arg3, arg4, arg5);
                    step();
                end
                "P": begin
                    start_retire(arg0, arg1, arg2);
                    step();
                end
                "R": begin
                    bus_read(arg0, rd);
                    check_value(rd, arg1, $sformatf("read of register %h", arg0[4:0]));
                end
                "T": begin
                    exp_time = cycle_cnt;
                    bus_read(REG_TRDB_TIME, rd);
                    check_value(rd, exp_time, "TIME register");
                end
                "I": repeat (arg0) step();
                "F": begin
                    // poll until the flush bit drops
                    rd = 32'h1;
                    while (rd[TRDB_FLUSH_STREAM]) begin
                        bus_read(REG_TRDB_CTRL, rd);
                    end
                    check_value(exp_sw_data.size(), 0, "software words pending at flush end");
                end
                default: abort_run($sformatf("unknown stimulus command: %s", cmds[i]));
            endcase
        end

        // let the last words come out, bounded like one stimulus line
        drain_cycles = 0;
        while ((exp_pkt_addr.size() != 0 || exp_sw_data.size() != 0) &&
               drain_cycles < 20) begin
            step();
            drain_cycles++;
        end
        step();

        if (exp_pkt_addr.size() == 0 && exp_sw_data.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort_run("expected words were still pending at the end");
        end
    end

endmodule

/* dv/trace_debugger_stim.txt */
# W reg data keep | M reg data keep addr priv pass | P addr priv pass | R reg expect
# T read TIME against cycle count | I idle cycles | F flush wait | all fields hex
R 00 00000000
R 08 00000002
W 00 00000055 0
R 00 00000055
W 00 ffffffff 0
R 00 0000007f
W 02 ffffffff 0
W 1e ffffffff 0
R 00 0000007f
W 14 00001000 0
W 18 00001ffc 0
R 14 00001000
R 18 00001ffc
T
R 0c 00000000
R 10 00000000
R 02 00000000
R 1e 00000000
W 00 00000003 0
P 00000100 0 1
P 00000200 3 1
P 00002000 1 1
W 00 0000006f 0
P 00000300 3 1
P 00000304 0 0
P 00000308 1 0
W 00 00000017 0
P 00000ffc 0 0
P 00001000 2 1
P 00001ffc 1 1
P 00002000 0 0
P 00001800 3 1
W 00 0000003f 0
P 00001004 1 1
P 00001008 0 0
P 00000004 1 0
W 00 0000007b 0
P 00000010 0 1
W 00 00000002 0
P 00000020 0 0
W 00 00000001 0
P 00000024 0 0
W 00 00000003 0
M 0c aaaa0001 1 00003000 0 1
P 00003004 0 1
M 0c aaaa0002 1 00003008 0 1
M 0c aaaa0003 1 0000300c 0 1
P 00003010 0 1
I 5
W 10 bbbb0001 1
I 4
P 00003100 0 1
W 10 bbbb0002 1
M 0c cccc0003 1 00003104 0 1
I 6
M 0c eeee0001 1 00004000 0 1
M 0c eeee0002 1 00004004 0 1
M 0c eeee0003 1 00004008 0 1
M 0c eeee0004 1 0000400c 0 1
M 0c eeee0005 0 00004010 0 1
P 00004014 0 1
I 8
R 08 00000003
W 08 00000000 0
R 08 00000003
W 08 00000001 0
R 08 00000002
W 0c dddd0001 1
W 10 dddd0002 1
W 0c dddd0003 1
W 04 00000001 0
R 04 00000001
F
R 04 00000000
R 08 00000002
T
I 4

/* trace_debugger.f */
verilog/trdb_pkg.sv
verilog/trdb_cfg_if.sv
verilog/trdb_reg.sv
verilog/trdb_filter.sv
verilog/trdb_sw_fifo.sv
verilog/trdb_stream_arbiter.sv
verilog/trace_debugger.sv
dv/trace_debugger_asserts.sv
dv/trace_debugger_tb.sv
